// File: files.f
source/uart_cfg_pkg.sv
source/uart_stream_pkg.sv
source/stream_fifo.sv
source/uart_tx.sv
source/uart_rx.sv
source/uart_stream.sv
tb/uart_stream_asserts.sv
tb/uart_stream_tb.sv

// File: run.sh
#!/bin/sh
# builds the simulation into obj_dir and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal -f files.f --top-module uart_stream_tb \
    -o uart_stream_sim &&
./obj_dir/uart_stream_sim +verilator+error+limit+1000 | tee /dev/stderr |
    grep -q "PASS: all tests" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb/uart_stream_tb.sv
`timescale 1ns/1ps

module uart_stream_tb;

    localparam int PS_A        = 2;
    localparam int PS_B        = 5;
    localparam int FRAME_A     = uart_cfg_pkg::FRAME_BITS * PS_A * uart_cfg_pkg::OVERSAMPLE;
    localparam int FRAME_B     = uart_cfg_pkg::FRAME_BITS * PS_B * uart_cfg_pkg::OVERSAMPLE;
    localparam int N_LOOP      = 12;
    localparam int N_FRAME_ERR = 2;
    localparam int N_OVERRUN   = 7;   // six while stalled, one after
    localparam int N_TX_BP     = 10;
    localparam int N_ACTIVE    = 3;
    localparam int N_PRESCALE  = 4;
    localparam int N_AT_A      = N_LOOP + N_FRAME_ERR + N_OVERRUN + N_TX_BP + N_ACTIVE;
    localparam int TIMEOUT_CYCLES = 2 * (N_AT_A * FRAME_A + N_PRESCALE * FRAME_B);

    logic                                clk = 1'b0;
    logic                                arst_n;
    logic [uart_cfg_pkg::PRESCALE_W-1:0] prescale;
    logic                                clear_errors;
    uart_stream_pkg::uart_status_t       status;
    uart_stream_pkg::tx_beat_t           utx_beat;
    logic                                utx_valid;
    logic                                utx_ready;
    uart_stream_pkg::rx_beat_t           urx_beat;
    logic                                urx_valid;
    logic                                urx_ready;
    logic                                txd;
    logic                                rxd;

    logic        loopback;
    logic        line_drive;   // tb-driven rxd when loopback is off
    logic        tx_stalled;
    logic [31:0] lfsr_state = 32'h102f_4233;
    int          cycle_count = 0;
    int          rx_count = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    logic [7:0]  exp_data [$];
    logic        exp_fe [$];
    logic [7:0]  tx_exp [$];

    assign rxd = loopback ? txd : line_drive;

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    uart_stream uut (
        .clk          (clk),
        .arst_n       (arst_n),
        .prescale     (prescale),
        .clear_errors (clear_errors),
        .status       (status),
        .utx_beat     (utx_beat),
        .utx_valid    (utx_valid),
        .utx_ready    (utx_ready),
        .urx_beat     (urx_beat),
        .urx_valid    (urx_valid),
        .urx_ready    (urx_ready),
        .txd          (txd),
        .rxd          (rxd)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            b[i] = lfsr_state[0];
        end
        return b;
    endfunction

    function automatic int error_total();
        return errors + uut.asserts_inst.assert_failures;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("Error at %0d ns: %s expected %0h got %0h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("Error at %0d ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        if (error_total() == mark) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d errors", name, error_total() - mark);
        end
    endtask

    task automatic expect_byte(input logic [7:0] b, input logic fe);
        exp_data.push_back(b);
        exp_fe.push_back(fe);
    endtask

    task automatic push_tx(input logic [7:0] b);
        utx_beat.data = b;
        utx_valid     = 1'b1;
        while (!utx_ready) begin
            tx_stalled = 1'b1;
            @(negedge clk);
        end
        @(negedge clk);  // the beat transfers on the rising edge in between
        utx_valid = 1'b0;
    endtask

    task automatic drive_rx_frame(input logic [7:0] b, input logic stop);
        int                                bit_cyc;
        logic [uart_cfg_pkg::FRAME_BITS-1:0] bits;
        bit_cyc = prescale * uart_cfg_pkg::OVERSAMPLE;
        bits    = {stop, b, 1'b0};
        for (int i = 0; i < uart_cfg_pkg::FRAME_BITS; i++) begin
            line_drive = bits[i];
            repeat (bit_cyc) @(negedge clk);
        end
        line_drive = 1'b1;  // an idle bit so a low stop bit still leaves a falling edge
        repeat (bit_cyc) @(negedge clk);
    endtask

    task automatic read_txd_frame(output logic [7:0] b, output logic stop);
        int bit_cyc;
        bit_cyc = prescale * uart_cfg_pkg::OVERSAMPLE;
        while (txd) @(negedge clk);
        repeat (bit_cyc / 2) @(negedge clk);
        check_true(!txd, "txd start bit went high before its middle");
        for (int i = 0; i < 8; i++) begin
            repeat (bit_cyc) @(negedge clk);
            b[i] = txd;
        end
        repeat (bit_cyc) @(negedge clk);
        stop = txd;
    endtask

    task automatic wait_rx(input int target);
        while (rx_count < target) @(negedge clk);
    endtask

    task automatic pulse_clear();
        clear_errors = 1'b1;
        @(negedge clk);
        clear_errors = 1'b0;
    endtask

    always @(posedge clk) begin
        if (urx_valid && urx_ready) begin
            if (exp_data.size() == 0) begin
                check_true(1'b0, "urx beat arrived with no byte expected");
            end else begin
                check_value("urx_beat.data", urx_beat.data, exp_data.pop_front());
                check_value("urx_beat.frame_error", urx_beat.frame_error, exp_fe.pop_front());
            end
            rx_count++;
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout after %0d cycles with tests still running", cycle_count);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [7:0] b;
        logic [7:0] rb;
        logic       rstop;
        int         mark;
        int         target;
        int         start_cycle;
        arst_n       = 1'b0;
        prescale     = PS_A;
        clear_errors = 1'b0;
        utx_beat     = '0;
        utx_valid    = 1'b0;
        urx_ready    = 1'b1;
        loopback     = 1'b0;
        line_drive   = 1'b1;
        tx_stalled   = 1'b0;
        repeat (5) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        mark = error_total();
        check_value("txd", txd, 1);
        check_value("utx_ready", utx_ready, 1);
        check_value("urx_valid", urx_valid, 0);
        check_value("status", status, 0);
        report_test("0 reset state", mark);

        mark     = error_total();
        loopback = 1'b1;
        target   = rx_count + N_LOOP;
        for (int i = 0; i < N_LOOP; i++) begin
            b = random_byte();
            expect_byte(b, 1'b0);
            push_tx(b);
        end
        wait_rx(target);
        report_test("1 loopback order and data", mark);

        // the beat reaches urx before the frame and its idle bit have been driven out
        mark     = error_total();
        loopback = 1'b0;
        b        = random_byte();
        target   = rx_count + 1;
        expect_byte(b, 1'b1);
        drive_rx_frame(b, 1'b0);
        wait_rx(target);
        check_value("status.frame_error", status.frame_error, 1);
        pulse_clear();
        check_value("status.frame_error", status.frame_error, 0);
        b      = random_byte();
        target = rx_count + 1;
        expect_byte(b, 1'b0);
        drive_rx_frame(b, 1'b1);
        wait_rx(target);
        check_value("status.frame_error", status.frame_error, 0);
        report_test("2 frame error", mark);

        mark      = error_total();
        urx_ready = 1'b0;
        for (int i = 0; i < N_OVERRUN - 1; i++) begin
            b = random_byte();
            if (i < uart_cfg_pkg::RX_FIFO_DEPTH) begin
                expect_byte(b, 1'b0);  // the rest are dropped
            end
            drive_rx_frame(b, 1'b1);
        end
        check_value("status.overrun", status.overrun, 1);
        target    = rx_count + uart_cfg_pkg::RX_FIFO_DEPTH;
        urx_ready = 1'b1;
        wait_rx(target);
        b = random_byte();
        expect_byte(b, 1'b0);
        drive_rx_frame(b, 1'b1);
        wait_rx(target + 1);
        check_value("status.overrun", status.overrun, 1);
        check_value("pending urx bytes", exp_data.size(), 0);
        pulse_clear();
        report_test("3 overrun", mark);

        mark       = error_total();
        tx_stalled = 1'b0;
        fork
            begin
                for (int i = 0; i < N_TX_BP; i++) begin
                    b = random_byte();
                    tx_exp.push_back(b);
                    push_tx(b);
                end
            end
            begin
                for (int i = 0; i < N_TX_BP; i++) begin
                    read_txd_frame(rb, rstop);
                    check_value("txd data", rb, tx_exp.pop_front());
                    check_value("txd stop bit", rstop, 1);
                end
            end
        join
        check_true(tx_stalled, "utx_ready never fell while the transmit FIFO was full");
        while (status.tx_active) @(negedge clk);
        report_test("4 transmit back-pressure", mark);

        mark     = error_total();
        loopback = 1'b1;
        target   = rx_count + N_ACTIVE;
        check_value("status.tx_active", status.tx_active, 0);
        b = random_byte();
        expect_byte(b, 1'b0);
        push_tx(b);
        start_cycle = cycle_count;
        check_value("status.tx_active", status.tx_active, 1);
        for (int i = 1; i < N_ACTIVE; i++) begin
            b = random_byte();
            expect_byte(b, 1'b0);
            push_tx(b);
        end
        while (status.tx_active) @(negedge clk);
        check_true(cycle_count - start_cycle >= N_ACTIVE * FRAME_A &&
                   cycle_count - start_cycle <= N_ACTIVE * FRAME_A + 8,
                   "tx_active fell outside the time of the queued frames");
        wait_rx(target);
        check_value("status.rx_active", status.rx_active, 0);
        report_test("5 activity status", mark);

        mark     = error_total();
        prescale = PS_B;
        target   = rx_count + N_PRESCALE;
        for (int i = 0; i < N_PRESCALE; i++) begin
            b = random_byte();
            expect_byte(b, 1'b0);
            push_tx(b);
        end
        wait_rx(target);
        report_test("6 prescale change", mark);

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0 && error_total() == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: tb/uart_stream_asserts.sv
`timescale 1ns/1ps

module uart_stream_asserts (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          clear_errors,
    input uart_stream_pkg::uart_status_t status,
    input uart_stream_pkg::tx_beat_t     utx_beat,
    input logic                          utx_valid,
    input logic                          utx_ready,
    input uart_stream_pkg::rx_beat_t     urx_beat,
    input logic                          urx_valid,
    input logic                          urx_ready,
    input logic                          tx_valid,
    input logic                          tx_ready,
    input logic                          tx_busy,
    input logic                          txd
);

    int assert_failures = 0;
    int waiting;  // beats taken on utx and not yet handed to the transmitter

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            waiting <= 0;
        end else begin
            waiting <= waiting + int'(utx_valid && utx_ready) - int'(tx_valid && tx_ready);
        end
    end

    utx_stable: assert property (@(posedge clk) disable iff (!arst_n)
        utx_valid && !utx_ready |=> utx_valid && $stable(utx_beat))
        else begin
            $error("utx beat changed or was withdrawn before it transferred");
            assert_failures++;
        end

    urx_stable: assert property (@(posedge clk) disable iff (!arst_n)
        urx_valid && !urx_ready |=> urx_valid && $stable(urx_beat))
        else begin
            $error("urx beat changed or was withdrawn before it transferred");
            assert_failures++;
        end

    txd_idle_high: assert property (@(posedge clk) disable iff (!arst_n) !tx_busy |-> txd)
        else begin
            $error("txd low while the transmitter is idle");
            assert_failures++;
        end

    // full FIFO is the only reason to hold off the transmit stream
    utx_ready_full: assert property (@(posedge clk) disable iff (!arst_n)
        utx_ready == (waiting != uart_cfg_pkg::TX_FIFO_DEPTH))
        else begin
            $error("utx_ready does not match %0d waiting beats", waiting);
            assert_failures++;
        end

    overrun_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(status.overrun) |-> $past(clear_errors))
        else begin
            $error("status overrun cleared without clear_errors");
            assert_failures++;
        end

    frame_error_sticky: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(status.frame_error) |-> $past(clear_errors))
        else begin
            $error("status frame_error cleared without clear_errors");
            assert_failures++;
        end

endmodule

bind uart_stream uart_stream_asserts asserts_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .clear_errors (clear_errors),
    .status       (status),
    .utx_beat     (utx_beat),
    .utx_valid    (utx_valid),
    .utx_ready    (utx_ready),
    .urx_beat     (urx_beat),
    .urx_valid    (urx_valid),
    .urx_ready    (urx_ready),
    .tx_valid     (tx_valid),
    .tx_ready     (tx_ready),
    .tx_busy      (tx_busy),
    .txd          (txd)
);

// File: source/uart_stream.sv
`timescale 1ns/1ps

module uart_stream (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [uart_cfg_pkg::PRESCALE_W-1:0] prescale,
    input  logic                                clear_errors,
    output uart_stream_pkg::uart_status_t       status,

    input  uart_stream_pkg::tx_beat_t           utx_beat,
    input  logic                                utx_valid,
    output logic                                utx_ready,

    output uart_stream_pkg::rx_beat_t           urx_beat,
    output logic                                urx_valid,
    input  logic                                urx_ready,

    output logic                                txd,
    input  logic                                rxd
);

    uart_stream_pkg::tx_beat_t tx_beat;
    logic                      tx_valid;
    logic                      tx_ready;
    logic                      tx_busy;
    logic                      tx_fifo_empty;

    uart_stream_pkg::rx_beat_t rx_beat;
    logic                      rx_valid;
    logic                      rx_fifo_ready;
    logic                      rx_busy;
    logic                      rx_fifo_empty;

    logic                      overrun_q;
    logic                      frame_error_q;

    stream_fifo #(
        .payload_t (uart_stream_pkg::tx_beat_t),
        .DEPTH     (uart_cfg_pkg::TX_FIFO_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_beat   (utx_beat),
        .in_valid  (utx_valid),
        .in_ready  (utx_ready),
        .out_beat  (tx_beat),
        .out_valid (tx_valid),
        .out_ready (tx_ready),
        .empty     (tx_fifo_empty)
    );

    uart_tx tx_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .beat     (tx_beat),
        .valid    (tx_valid),
        .ready    (tx_ready),
        .prescale (prescale),
        .txd      (txd),
        .busy     (tx_busy)
    );

    uart_rx rx_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .rxd      (rxd),
        .prescale (prescale),
        .beat     (rx_beat),
        .valid    (rx_valid),
        .busy     (rx_busy)
    );

    // the receiver cannot stall, so a full FIFO loses the beat
    stream_fifo #(
        .payload_t (uart_stream_pkg::rx_beat_t),
        .DEPTH     (uart_cfg_pkg::RX_FIFO_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_beat   (rx_beat),
        .in_valid  (rx_valid),
        .in_ready  (rx_fifo_ready),
        .out_beat  (urx_beat),
        .out_valid (urx_valid),
        .out_ready (urx_ready),
        .empty     (rx_fifo_empty)
    );

    // an event in the same cycle as clear_errors keeps the flag set
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            overrun_q     <= 1'b0;
            frame_error_q <= 1'b0;
        end else begin
            if (rx_valid && !rx_fifo_ready) begin
                overrun_q <= 1'b1;
            end else if (clear_errors) begin
                overrun_q <= 1'b0;
            end
            if (rx_valid && rx_beat.frame_error) begin
                frame_error_q <= 1'b1;
            end else if (clear_errors) begin
                frame_error_q <= 1'b0;
            end
        end
    end

    always_comb begin
        status             = '0;
        status.tx_active   = tx_busy || !tx_fifo_empty;
        status.rx_active   = rx_busy || !rx_fifo_empty;
        status.overrun     = overrun_q;
        status.frame_error = frame_error_q;
    end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                rxd,
    input  logic [uart_cfg_pkg::PRESCALE_W-1:0] prescale,
    output uart_stream_pkg::rx_beat_t           beat,
    output logic                                valid,
    output logic                                busy
);

    localparam int DATA_BITS = uart_cfg_pkg::DATA_BITS;
    localparam int PERIOD_W  = uart_cfg_pkg::PERIOD_W;
    localparam int BIT_CNT_W = (DATA_BITS > 1) ? $clog2(DATA_BITS) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t                 state_q;
    logic                   rxd_meta;
    logic                   rxd_s;
    logic                   rxd_q;     // previous synchronized value, for edge detection
    logic [PERIOD_W-1:0]    period_q;
    logic [PERIOD_W-1:0]    cnt_q;
    logic [BIT_CNT_W-1:0]   bits_left_q;
    logic [DATA_BITS-1:0]   shift_q;

    logic                   fall;
    logic                   tick;
    logic [PERIOD_W-1:0]    new_period;

    assign new_period = PERIOD_W'(prescale) * PERIOD_W'(uart_cfg_pkg::OVERSAMPLE);
    assign fall       = rxd_q && !rxd_s;
    assign tick       = (cnt_q == '0);

    // the beat in flight to the FIFO still counts as receiver activity
    assign busy = (state_q != ST_IDLE) || valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rxd_meta <= 1'b1;
            rxd_s    <= 1'b1;
            rxd_q    <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_s    <= rxd_meta;
            rxd_q    <= rxd_s;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= ST_IDLE;
            cnt_q       <= '0;
            bits_left_q <= '0;
            valid       <= 1'b0;
        end else begin
            valid <= 1'b0;
            if (state_q == ST_IDLE) begin
                if (fall) begin
                    state_q <= ST_START;
                    cnt_q   <= (new_period >> 1) - 1'b1;  // wait to the middle of the start bit
                end
            end else if (!tick) begin
                cnt_q <= cnt_q - 1'b1;
            end else begin
                cnt_q <= period_q - 1'b1;
                case (state_q)
                    ST_START: begin
                        // line back high means a glitch, not a start bit
                        state_q     <= rxd_s ? ST_IDLE : ST_DATA;
                        bits_left_q <= BIT_CNT_W'(DATA_BITS - 1);
                    end
                    ST_DATA: begin
                        if (bits_left_q == '0) begin
                            state_q <= ST_STOP;
                        end
                        bits_left_q <= bits_left_q - 1'b1;
                    end
                    default: begin
                        state_q <= ST_IDLE;
                        valid   <= 1'b1;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && fall) begin
            period_q <= new_period;
        end
        if (state_q == ST_DATA && tick) begin
            shift_q <= {rxd_s, shift_q[DATA_BITS-1:1]};  // LSB arrives first
        end
        if (state_q == ST_STOP && tick) begin
            beat.data        <= shift_q;
            beat.frame_error <= !rxd_s;
        end
    end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx (
    input  logic                                clk,
    input  logic                                arst_n,
    input  uart_stream_pkg::tx_beat_t           beat,
    input  logic                                valid,
    output logic                                ready,
    input  logic [uart_cfg_pkg::PRESCALE_W-1:0] prescale,
    output logic                                txd,
    output logic                                busy
);

    localparam int FRAME_BITS = uart_cfg_pkg::FRAME_BITS;
    localparam int PERIOD_W   = uart_cfg_pkg::PERIOD_W;
    localparam int BIT_CNT_W  = $clog2(FRAME_BITS);

    logic [PERIOD_W-1:0]   period_q;    // bit period latched when the frame starts
    logic [PERIOD_W-1:0]   cnt_q;
    logic [BIT_CNT_W-1:0]  bits_left_q;
    logic [FRAME_BITS-2:0] shift_q;     // data LSB first, then the stop bit

    logic                  accept;
    logic                  bit_done;
    logic                  bit_step;
    logic [PERIOD_W-1:0]   new_period;

    assign accept     = valid && ready;
    assign new_period = PERIOD_W'(prescale) * PERIOD_W'(uart_cfg_pkg::OVERSAMPLE);
    assign bit_done   = busy && (cnt_q == '0);
    assign bit_step   = bit_done && (bits_left_q != '0);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ready       <= 1'b1;
            busy        <= 1'b0;
            txd         <= 1'b1;  // line idles high
            cnt_q       <= '0;
            bits_left_q <= '0;
        end else if (accept) begin
            ready       <= 1'b0;
            busy        <= 1'b1;
            txd         <= 1'b0;  // start bit
            cnt_q       <= new_period - 1'b1;
            bits_left_q <= BIT_CNT_W'(FRAME_BITS - 1);
        end else if (busy) begin
            if (!bit_done) begin
                cnt_q <= cnt_q - 1'b1;
            end else if (bit_step) begin
                txd         <= shift_q[0];
                cnt_q       <= period_q - 1'b1;
                bits_left_q <= bits_left_q - 1'b1;
            end else begin
                // stop bit has run its full period
                busy  <= 1'b0;
                ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            period_q <= new_period;
            shift_q  <= {1'b1, beat.data};
        end else if (bit_step) begin
            shift_q <= {1'b1, shift_q[FRAME_BITS-2:1]};
        end
    end

endmodule

// File: source/stream_fifo.sv
`timescale 1ns/1ps

module stream_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     arst_n,
    input  payload_t in_beat,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_beat,
    output logic     out_valid,
    input  logic     out_ready,
    output logic     empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // the output stage holds one beat, so the buffer never carries more than DEPTH-1
    payload_t   mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;   // beats held in buffer and output stage together

    logic push;
    logic pop;
    logic mem_empty;
    logic stage_free;
    logic load_out;
    logic write_mem;
    logic [PTR_W-1:0] wr_ptr_next;
    logic [PTR_W-1:0] rd_ptr_next;

    assign in_ready  = (count_q != CNT_W'(DEPTH));
    assign empty     = (count_q == '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign mem_empty = (rd_ptr_q == wr_ptr_q);

    // output register is free this cycle if it is empty or being drained
    assign stage_free = !out_valid || out_ready;
    assign load_out   = stage_free && (!mem_empty || push);

    // a beat skips the buffer when nothing is queued in front of it
    assign write_mem = push && !(stage_free && mem_empty);

    assign wr_ptr_next = (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
    assign rd_ptr_next = (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            count_q   <= '0;
            out_valid <= 1'b0;
        end else begin
            if (write_mem) begin
                wr_ptr_q <= wr_ptr_next;
            end
            if (stage_free && !mem_empty) begin
                rd_ptr_q <= rd_ptr_next;
            end
            if (stage_free) begin
                out_valid <= !mem_empty || push;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (write_mem) begin
            mem[wr_ptr_q] <= in_beat;
        end
        if (load_out) begin
            out_beat <= mem_empty ? in_beat : mem[rd_ptr_q];
        end
    end

endmodule

// File: source/uart_stream_pkg.sv
package uart_stream_pkg;

    // one character on the transmit stream
    typedef struct packed {
        logic [uart_cfg_pkg::DATA_BITS-1:0] data;
    } tx_beat_t;

    // one character on the receive stream, with the stop-bit check
    typedef struct packed {
        logic                               frame_error; // stop bit was sampled low
        logic [uart_cfg_pkg::DATA_BITS-1:0] data;
    } rx_beat_t;

    // frame_error is the MSB and tx_active sits in bit 0
    typedef struct packed {
        logic frame_error; // sticky until clear_errors
        logic overrun;     // sticky until clear_errors
        logic rx_active;
        logic tx_active;
    } uart_status_t;

endpackage

// File: source/uart_cfg_pkg.sv
package uart_cfg_pkg;

    // character format, 8N1
    localparam int DATA_BITS  = 8;
    localparam int START_BITS = 1;
    localparam int STOP_BITS  = 1;
    localparam int FRAME_BITS = START_BITS + DATA_BITS + STOP_BITS;

    // one prescale unit is OVERSAMPLE clk cycles, so a bit lasts prescale * OVERSAMPLE cycles
    localparam int OVERSAMPLE = 8;
    localparam int PRESCALE_W = 16;

    // wide enough to hold a full bit period in clk cycles
    localparam int PERIOD_W = PRESCALE_W + $clog2(OVERSAMPLE);

    // total beats each FIFO can hold, output stage included
    localparam int TX_FIFO_DEPTH = 8;
    localparam int RX_FIFO_DEPTH = 4;

endpackage
